// File: common/cache_pkg.sv
`default_nettype none

// shared types for the direct mapped read-only cache
package cache_pkg;

	// address split: tag | set index | word select | byte bit
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;
	localparam int TAG_W = 9;
	localparam int INDEX_W = 3;
	localparam int WSEL_W = 3;
	localparam int COUNT_W = 4;

	// geometry
	localparam int NUM_SETS = 8;
	localparam int WORDS_PER_BLOCK = 8;

	// widths that carry a meaning
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [WSEL_W-1:0] word_sel_t;
	// fill counter, reaches WORDS_PER_BLOCK when a block is complete
	typedef logic [COUNT_W-1:0] count_t;

	// fill machine states
	typedef enum logic {
		FILL_IDLE = 1'b0,
		FILL_BUSY = 1'b1
	} fill_state_t;

	// processor read request, held while stall is high
	typedef struct packed {
		logic valid;
		addr_t addr;
	} cpu_req_t;

	// tag and valid bit update, one per completed fill
	typedef struct packed {
		logic en;
		index_t index;
		tag_t tag;
	} tag_write_t;

	// one word landing in the data array
	typedef struct packed {
		logic en;
		index_t index;
		word_sel_t word;
		word_t data;
	} fill_write_t;

	// memory read request, transfers when read and mem_ready are both high
	typedef struct packed {
		logic read;
		addr_t addr;
	} mem_req_t;

endpackage

`default_nettype wire

// File: cache/cache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

// address decode plus the tag/valid arrays that decide hit or miss
module cache_lookup import cache_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	// request from the processor
	input wire cpu_req_t req,
	// tag update from the fill machine
	input wire tag_write_t tag_wr,
	output logic hit,
	output logic miss_detected,
	// decoded address fields
	output index_t req_index,
	output word_sel_t req_word,
	output tag_t req_tag
);

	// one tag and one valid bit per set
	tag_t tag_q [NUM_SETS];
	logic [NUM_SETS-1:0] valid_q;

	// tag comparison result for the addressed set
	logic tag_match;
	logic set_valid;

	// byte bit 0 is ignored since loads are word sized
	assign req_tag = req.addr[ADDR_W-1 -: TAG_W];
	assign req_index = req.addr[WSEL_W+1 +: INDEX_W];
	assign req_word = req.addr[1 +: WSEL_W];

	// look up the addressed set
	assign set_valid = valid_q[req_index];
	assign tag_match = (tag_q[req_index] == req_tag);

	// hit needs a valid request on a valid set with matching tag
	assign hit = req.valid && set_valid && tag_match;

	// a miss is combinational so stall rises in the same cycle
	assign miss_detected = req.valid && !hit;

	// valid bits are all cleared by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (tag_wr.en) begin
			// set becomes valid once its whole block has landed
			valid_q[tag_wr.index] <= 1'b1;
		end
	end

	// tag storage
	always_ff @(posedge clk) begin
		if (tag_wr.en) begin
			tag_q[tag_wr.index] <= tag_wr.tag;
		end
	end

endmodule

`default_nettype wire

// File: cache/cache_fill_fsm.sv
`timescale 1ns/100ps
`default_nettype none

// miss handling machine
// issues the eight word reads of a block back to back and
// collects the returns in order with a separate counter
module cache_fill_fsm import cache_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	// from the lookup
	input wire logic miss_detected,
	input wire tag_t req_tag,
	input wire index_t req_index,
	// memory side
	input wire logic mem_ready,
	input wire word_t mem_data,
	input wire logic mem_data_valid,
	// busy doubles as the pipeline stall
	output logic busy,
	output mem_req_t mem_req,
	output fill_write_t fill_wr,
	output tag_write_t tag_wr
);

	fill_state_t state, next_state;

	// requests accepted by memory so far
	count_t issue_cnt;
	// words returned so far
	count_t ret_cnt;

	// block being filled, captured when the miss is taken
	tag_t fill_tag;
	index_t fill_index;

	logic issue_done;
	logic ret_done;
	logic issue_fire;
	logic start;

	assign busy = (state == FILL_BUSY);
	assign start = (state == FILL_IDLE) && miss_detected;

	assign issue_done = (issue_cnt == count_t'(WORDS_PER_BLOCK));
	assign ret_done = (ret_cnt == count_t'(WORDS_PER_BLOCK));

	// keep asking until eight reads have been accepted
	assign mem_req.read = busy && !issue_done;
	assign mem_req.addr = {fill_tag, fill_index, issue_cnt[WSEL_W-1:0], 1'b0};
	assign issue_fire = mem_req.read && mem_ready;

	// returns come back in issue order, so the return count is the word select
	assign fill_wr.en = busy && mem_data_valid && !ret_done;
	assign fill_wr.index = fill_index;
	assign fill_wr.word = ret_cnt[WSEL_W-1:0];
	assign fill_wr.data = mem_data;

	// tag and valid go in the cycle after the eighth word landed
	assign tag_wr.en = busy && ret_done;
	assign tag_wr.index = fill_index;
	assign tag_wr.tag = fill_tag;

	always_comb begin
		next_state = state;
		case (state)
			FILL_IDLE: if (miss_detected) next_state = FILL_BUSY;
			FILL_BUSY: if (ret_done) next_state = FILL_IDLE;
			default: next_state = FILL_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FILL_IDLE;
			issue_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			state <= next_state;
			if (start) begin
				// fresh block, both counters restart
				issue_cnt <= '0;
				ret_cnt <= '0;
			end else begin
				// mem_ready low simply holds the issue count
				if (issue_fire) issue_cnt <= issue_cnt + 1'b1;
				if (fill_wr.en) ret_cnt <= ret_cnt + 1'b1;
			end
		end
	end

	// latch the missing block on the way into FILL_BUSY
	always_ff @(posedge clk) begin
		if (start) begin
			fill_tag <= req_tag;
			fill_index <= req_index;
		end
	end

endmodule

`default_nettype wire

// File: cache/cache_data_array.sv
`timescale 1ns/100ps
`default_nettype none

// block storage, sets by words
// filled one word at a time, read with a registered output
module cache_data_array import cache_pkg::*; (
	input wire logic clk,
	// write port from the fill machine
	input wire fill_write_t fill_wr,
	// read port, enabled by a hit
	input wire logic rd_en,
	input wire index_t rd_index,
	input wire word_sel_t rd_word,
	output word_t rdata,
	output logic rdata_valid,
	input wire logic rst
);

	// 64 words in total
	word_t mem [NUM_SETS][WORDS_PER_BLOCK];

	// fill write
	always_ff @(posedge clk) begin
		if (fill_wr.en) begin
			mem[fill_wr.index][fill_wr.word] <= fill_wr.data;
		end
	end

	// read data register, only loads on a hit
	// so rdata holds its last value otherwise
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= mem[rd_index][rd_word];
		end
	end

	// valid strobe follows rd_en by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= rd_en;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

// read-only direct mapped cache
// lookup decides hit or miss, the fill machine services misses,
// the data array delivers the word
module cache_top import cache_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	// processor port
	input wire cpu_req_t req,
	output logic stall,
	output word_t rdata,
	output logic rdata_valid,
	// memory port
	output mem_req_t mem_req,
	input wire logic mem_ready,
	input wire word_t mem_data,
	input wire logic mem_data_valid
);

	// lookup results
	logic hit;
	logic miss_detected;
	index_t req_index;
	word_sel_t req_word;
	tag_t req_tag;

	// fill machine outputs
	logic busy;
	fill_write_t fill_wr;
	tag_write_t tag_wr;

	// processor holds its request while this is high
	assign stall = miss_detected | busy;

	cache_lookup u_lookup (
		.clk (clk),
		.rst (rst),
		.req (req),
		.tag_wr (tag_wr),
		.hit (hit),
		.miss_detected (miss_detected),
		.req_index (req_index),
		.req_word (req_word),
		.req_tag (req_tag)
	);

	cache_fill_fsm u_fill (
		.clk (clk),
		.rst (rst),
		.miss_detected (miss_detected),
		.req_tag (req_tag),
		.req_index (req_index),
		.mem_ready (mem_ready),
		.mem_data (mem_data),
		.mem_data_valid (mem_data_valid),
		.busy (busy),
		.mem_req (mem_req),
		.fill_wr (fill_wr),
		.tag_wr (tag_wr)
	);

	// hit is the read enable, word comes out one cycle later
	cache_data_array u_data (
		.clk (clk),
		.fill_wr (fill_wr),
		.rd_en (hit),
		.rd_index (req_index),
		.rd_word (req_word),
		.rdata (rdata),
		.rdata_valid (rdata_valid),
		.rst (rst)
	);

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

// behavioral main memory with a fixed read latency
// takes a request when read and mem_ready meet and returns strictly in order
module mem_model import cache_pkg::*; #(
	parameter word_t DATA_XOR = 16'hA5C3
) (
	input wire logic clk,
	input wire logic rst,
	// random ready gaps only while this is high
	input wire logic gap_en,
	input wire mem_req_t mem_req,
	output logic mem_ready,
	output word_t mem_data,
	output logic mem_data_valid,
	// sticky flag for a repeated or foreign address inside one fill
	output logic bad_request
);

	localparam int LATENCY = 4;
	localparam logic [15:0] SEED = 16'd29;

	// galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	logic [15:0] lfsr;
	// return pipeline with the oldest entry in slot LATENCY-1
	logic pipe_vld [LATENCY];
	word_t pipe_data [LATENCY];
	// addresses handed out during the current fill
	addr_t fill_addrs [$];
	logic ready_now;
	logic fire;

	// quiet memory bus until the first falling edge
	initial begin
		mem_ready = 1'b0;
		mem_data_valid = 1'b0;
		mem_data = '0;
		bad_request = 1'b0;
	end

	// everything moves on the falling edge while the cache samples on the rising one
	always @(negedge clk) begin
		if (rst) begin
			lfsr = SEED;
			mem_ready <= 1'b0;
			mem_data_valid <= 1'b0;
			mem_data <= '0;
			bad_request <= 1'b0;
			for (int i = 0; i < LATENCY; i++) begin
				pipe_vld[i] = 1'b0;
				pipe_data[i] = '0;
			end
			fill_addrs.delete();
		end else begin
			ready_now = 1'b1;
			if (gap_en) begin
				// one lfsr bit per cycle and a zero means a gap
				ready_now = lfsr[0];
				lfsr = lfsr_step(lfsr);
			end
			fire = mem_req.read && ready_now;
			mem_ready <= ready_now;
			// oldest entry goes onto the return bus
			mem_data_valid <= pipe_vld[LATENCY-1];
			mem_data <= pipe_data[LATENCY-1];
			for (int i = LATENCY - 1; i > 0; i--) begin
				pipe_vld[i] = pipe_vld[i-1];
				pipe_data[i] = pipe_data[i-1];
			end
			pipe_vld[0] = fire;
			pipe_data[0] = mem_req.addr ^ DATA_XOR;
			// strobe low means the previous fill has issued everything
			if (!mem_req.read) begin
				fill_addrs.delete();
			end
			if (fire) begin
				foreach (fill_addrs[j]) begin
					if (fill_addrs[j] == mem_req.addr) begin
						$display("memory model: address %h requested twice", mem_req.addr);
						bad_request <= 1'b1;
					end
				end
				if (fill_addrs.size() > 0 && fill_addrs[0][15:4] != mem_req.addr[15:4]) begin
					$display("memory model: address %h outside the block", mem_req.addr);
					bad_request <= 1'b1;
				end
				fill_addrs.push_back(mem_req.addr);
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

// testbench for the read-only direct mapped cache
module tb_cache import cache_pkg::*; ();

	localparam word_t DATA_RULE = 16'hA5C3;
	localparam int FILL_TIMEOUT = 200;
	localparam int NUM_STEPS = 35;

	// one processor read and whether memory gaps are on
	typedef struct packed {
		addr_t addr;
		logic gaps;
	} step_t;

	logic clk;
	logic rst;
	cpu_req_t req;
	logic stall;
	word_t rdata;
	logic rdata_valid;
	mem_req_t mem_req;
	logic mem_ready;
	word_t mem_data;
	logic mem_data_valid;
	logic gap_en;
	logic bad_request;

	step_t steps [NUM_STEPS];
	// which block each set should hold
	tag_t model_tag [NUM_SETS];
	logic [NUM_SETS-1:0] model_valid;

	cache_top dut (
		.clk (clk),
		.rst (rst),
		.req (req),
		.stall (stall),
		.rdata (rdata),
		.rdata_valid (rdata_valid),
		.mem_req (mem_req),
		.mem_ready (mem_ready),
		.mem_data (mem_data),
		.mem_data_valid (mem_data_valid)
	);

	mem_model #(.DATA_XOR(DATA_RULE)) u_mem (
		.clk (clk),
		.rst (rst),
		.gap_en (gap_en),
		.mem_req (mem_req),
		.mem_ready (mem_ready),
		.mem_data (mem_data),
		.mem_data_valid (mem_data_valid),
		.bad_request (bad_request)
	);

	// 8 ns period
	always #4 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s, got %h expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s, got %b expected %b", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// memory word rule is the byte address xor a constant
	function automatic word_t rule_word(input addr_t a);
		return a ^ DATA_RULE;
	endfunction

	// tag in bits 15..7 and set in bits 6..4
	function automatic logic predict_miss(input addr_t a);
		return !(model_valid[a[6:4]] && model_tag[a[6:4]] == a[15:7]);
	endfunction

	task automatic check_idle_outputs(input string when);
		check_flag(stall, 1'b0, {"stall ", when});
		check_flag(rdata_valid, 1'b0, {"rdata_valid ", when});
		check_flag(mem_req.read, 1'b0, {"memory read strobe ", when});
	endtask

	// starts on a falling edge and returns half a cycle after the word is checked
	task automatic run_read(input addr_t a, input logic exp_miss);
		int waited;
		waited = 0;
		req.valid = 1'b1;
		req.addr = a;
		#1;
		// a miss raises stall in the request cycle and a hit never does
		check_flag(stall, exp_miss, "stall in first request cycle");
		while (stall) begin
			check_flag(rdata_valid, 1'b0, "rdata_valid while stalled");
			if (waited == FILL_TIMEOUT) begin
				abort_run("timed out waiting for stall to fall during a fill");
			end
			waited++;
			@(negedge clk);
			#1;
		end
		// accepted on the coming rising edge
		@(negedge clk);
		req.valid = 1'b0;
		req.addr = '0;
		#1;
		check_flag(rdata_valid, 1'b1, "rdata_valid one cycle after acceptance");
		check_word(rdata, rule_word(a), "read data");
	endtask

	task automatic load_table();
		// cold miss followed by every word of that block
		steps[0] = '{16'h1234, 1'b0};
		steps[1] = '{16'h1230, 1'b0};
		steps[2] = '{16'h1232, 1'b0};
		steps[3] = '{16'h1234, 1'b0};
		steps[4] = '{16'h1236, 1'b0};
		steps[5] = '{16'h1238, 1'b0};
		steps[6] = '{16'h123A, 1'b0};
		steps[7] = '{16'h123C, 1'b0};
		steps[8] = '{16'h123E, 1'b0};
		// set 3 conflicts
		steps[9] = '{16'h5634, 1'b0};
		steps[10] = '{16'h563A, 1'b0};
		steps[11] = '{16'h1238, 1'b0};
		steps[12] = '{16'h5630, 1'b0};
		steps[13] = '{16'h563E, 1'b0};
		// fills with ready gaps and a conflict in set 6
		steps[14] = '{16'hBEE0, 1'b1};
		steps[15] = '{16'hBEEE, 1'b1};
		steps[16] = '{16'h7F62, 1'b1};
		steps[17] = '{16'h7F6C, 1'b1};
		steps[18] = '{16'hBEE4, 1'b1};
		// one new block in every set
		steps[19] = '{16'h4A02, 1'b1};
		steps[20] = '{16'h4A14, 1'b1};
		steps[21] = '{16'h4A26, 1'b1};
		steps[22] = '{16'h4A38, 1'b1};
		steps[23] = '{16'h4A4A, 1'b1};
		steps[24] = '{16'h4A5C, 1'b1};
		steps[25] = '{16'h4A6E, 1'b1};
		steps[26] = '{16'h4A70, 1'b1};
		// all still resident
		steps[27] = '{16'h4A0E, 1'b0};
		steps[28] = '{16'h4A1C, 1'b0};
		steps[29] = '{16'h4A2A, 1'b0};
		steps[30] = '{16'h4A30, 1'b0};
		steps[31] = '{16'h4A46, 1'b0};
		steps[32] = '{16'h4A58, 1'b0};
		steps[33] = '{16'h4A64, 1'b0};
		steps[34] = '{16'h4A7A, 1'b0};
	endtask

	always @(negedge clk) begin
		if (bad_request === 1'b1) begin
			abort_run("memory model saw a repeated or stray address within one fill");
		end
	end

	initial begin
		logic exp_miss;
		clk = 1'b0;
		rst = 1'b1;
		req = '0;
		gap_en = 1'b0;
		model_valid = '0;
		load_table();
		// outputs stay quiet from the first reset edge on
		for (int i = 0; i < 15; i++) begin
			@(negedge clk);
			#1;
			check_idle_outputs("during reset");
		end
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 2; i++) begin
			@(negedge clk);
			#1;
			check_idle_outputs("after reset");
		end
		foreach (steps[n]) begin
			gap_en = steps[n].gaps;
			// hit or miss comes from the tag model
			exp_miss = predict_miss(steps[n].addr);
			@(negedge clk);
			run_read(steps[n].addr, exp_miss);
			if (exp_miss) begin
				model_valid[steps[n].addr[6:4]] = 1'b1;
				model_tag[steps[n].addr[6:4]] = steps[n].addr[15:7];
			end
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
common/cache_pkg.sv
cache/cache_lookup.sv
cache/cache_fill_fsm.sv
cache/cache_data_array.sv
hdl/cache_top.sv
bench/mem_model.sv
bench/tb_cache.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_cache -f sim.f -o tb_cache_sim
	-./obj_dir/tb_cache_sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
